// File: Makefile
TOOL       := verilator
TOP        := tb_weight_load
FILELIST   := vlog.f
FLAGS      := --timing --timescale 1ns/100ps
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary -j 0
OBJ_DIR    := obj_dir
PASS_MSG   := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# pass only when the pass line shows up in the output
sim:
	$(TOOL) $(SIM_FLAGS) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_weight_load.sv
`timescale 1ns/100ps
`default_nettype none

module tb_weight_load
  import weight_load_pkg::*;
();

  localparam int NUM_ROWS     = 6;
  localparam int HOLD_CYCLES  = 6;
  localparam int GATE_CYCLES  = 12;
  localparam int POP_TIMEOUT  = 200;
  localparam int LOAD_TIMEOUT = 5000;

  // one stimulus row with its expected results
  typedef struct packed {
    instr_t    word;
    instr_t    word2;
    logic      hold_full;
    logic      set_before;
    logic      bad_beats;
    int        exp_words;
    axi_addr_t exp_addr0;
    axi_addr_t exp_addr1;
    axi_len_t  exp_len0;
    axi_len_t  exp_len1;
    int        exp_beats;
    int        exp_prep;
    int        exp_bias;
  } row_t;

  logic      clk = 1'b0;
  logic      rst_n = 1'b0;
  logic      i_instr_empty = 1'b1;
  instr_t    i_instr = '0;
  logic      o_instr_rd_en;
  logic      i_fwd_full = 1'b0;
  logic      o_fwd_wr_en;
  logic      i_set_weight = 1'b0;
  ar_chan_t  o_ar;
  logic      i_arready = 1'b0;
  r_chan_t   i_r = '0;
  logic      o_rready;
  logic      o_weight_wr_en;
  beat_sel_t o_weight_sel;
  logic      o_prepare_weight;
  logic      o_bias_wr_en;
  logic      o_param_wr_en;
  logic      o_idle;

  row_t        rows [NUM_ROWS];
  int          errors = 0;
  int          timeouts = 0;
  int          pops = 0;
  int          beats = 0;
  int          preps = 0;
  int          biases = 0;
  int          beats_left = 0;
  beat_sel_t   sel_exp = '0;
  logic        prep_due = 1'b0;
  logic        good_beat;
  logic        rready_exp = 1'b0;
  // beat on the bus carries a wrong id or an error response
  logic        bad_sent = 1'b0;
  logic        bias_row = 1'b0;
  logic [1:0]  strobe_due = 2'b00;
  logic        inject_bad = 1'b0;
  logic        ready_model = 1'b1;
  logic [31:0] lcg_state = 32'h5f91;
  logic [31:0] rnd;
  // instruction fifo contents, head at index 0
  instr_t      instr_q [$];
  instr_t      fwd_q [$];
  axi_addr_t   ar_addr_q [$];
  axi_len_t    ar_len_q [$];

  always #20 clk = ~clk;

  weight_load_top u_weight_load_top (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_instr_empty    (i_instr_empty),
    .i_instr          (i_instr),
    .o_instr_rd_en    (o_instr_rd_en),
    .i_fwd_full       (i_fwd_full),
    .o_fwd_wr_en      (o_fwd_wr_en),
    .i_set_weight     (i_set_weight),
    .o_ar             (o_ar),
    .i_arready        (i_arready),
    .i_r              (i_r),
    .o_rready         (o_rready),
    .o_weight_wr_en   (o_weight_wr_en),
    .o_weight_sel     (o_weight_sel),
    .o_prepare_weight (o_prepare_weight),
    .o_bias_wr_en     (o_bias_wr_en),
    .o_param_wr_en    (o_param_wr_en),
    .o_idle           (o_idle)
  );

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_instr(input string name, input instr_t got, input instr_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input axi_addr_t got, input axi_addr_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_len(input string name, input axi_len_t got, input axi_len_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input axi_id_t got, input axi_id_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_attr(input string name, input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_sel(input string name, input beat_sel_t got, input beat_sel_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %0h expected %0h", name, got, exp);
    end
  endtask

  // lcg step, numerical recipes constants
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // monitor, sampled at the rising edge before any register update
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      // fifo side
      if (o_instr_rd_en && i_instr_empty)
      begin
        errors++;
        $display("instruction FIFO popped while it was empty");
      end
      else if (o_instr_rd_en)
      begin
        pops++;
        if (o_fwd_wr_en)
        begin
          fwd_q.push_back(i_instr);
        end
        void'(instr_q.pop_front());
      end
      if (o_fwd_wr_en && (i_fwd_full || !o_instr_rd_en))
      begin
        errors++;
        $display("activation FIFO written while full or without a pop");
      end
      // rready from the cycle after the handshake to the cycle after rlast
      check_bit("o_rready", o_rready, rready_exp);
      // address handshake starts a burst
      if (o_ar.arvalid && i_arready)
      begin
        check_id("o_ar.arid", o_ar.arid, WEIGHT_MEM_ID);
        check_attr("o_ar.arsize", o_ar.arsize, 3'b010);
        check_attr("o_ar.arburst", {1'b0, o_ar.arburst}, 3'b001);
        ar_addr_q.push_back(o_ar.araddr);
        ar_len_q.push_back(o_ar.arlen);
        beats_left = int'(o_ar.arlen) + 1;
        sel_exp = '0;
        rready_exp = 1'b1;
      end
      // corrupted beats from the slave model never count
      good_beat = i_r.rvalid && rready_exp && !bad_sent;
      check_bit("o_weight_wr_en", o_weight_wr_en, good_beat);
      check_bit("o_prepare_weight", o_prepare_weight, prep_due);
      prep_due = good_beat && (sel_exp == 5'd31);
      if (good_beat)
      begin
        check_sel("o_weight_sel", o_weight_sel, sel_exp);
        sel_exp = sel_exp + 5'd1;
        beats++;
        beats_left--;
        if (i_r.rlast)
        begin
          rready_exp = 1'b0;
        end
      end
      if (o_prepare_weight)
      begin
        preps++;
      end
      // bias and param two cycles after the last beat of a bias load
      check_bit("o_bias_wr_en", o_bias_wr_en, strobe_due[1]);
      check_bit("o_param_wr_en", o_param_wr_en, strobe_due[1]);
      strobe_due = {strobe_due[0],
                    good_beat && i_r.rlast && bias_row && (ar_addr_q.size() == 2)};
      if (o_bias_wr_en)
      begin
        biases++;
      end
    end
  end

  // axi read slave, random arready and rvalid gaps
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      rnd = lcg_next();
      i_arready = (rnd[17:16] != 2'b00);
      rnd = lcg_next();
      if (beats_left > 0 && rnd[20:19] != 2'b00)
      begin
        i_r.rvalid = 1'b1;
        i_r.rlast  = (beats_left == 1);
        i_r.rid    = WEIGHT_MEM_ID;
        i_r.rresp  = 2'b00;
        bad_sent   = 1'b0;
        // wrong id or slverr, consumed but not counted
        if (inject_bad && rnd[25:23] == 3'd0)
        begin
          i_r.rid  = 4'h5;
          bad_sent = 1'b1;
        end
        else if (inject_bad && rnd[25:23] == 3'd1)
        begin
          i_r.rresp = 2'b10;
          bad_sent  = 1'b1;
        end
      end
      else
      begin
        i_r = '0;
        bad_sent = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // sequencing helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic present_head();
    i_instr_empty = (instr_q.size() == 0);
    i_instr = (instr_q.size() == 0) ? '0 : instr_q[0];
  endtask

  task automatic next_cycle();
    @(negedge clk);
    present_head();
  endtask

  task automatic pulse_set_weight();
    i_set_weight = 1'b1;
    next_cycle();
    i_set_weight = 1'b0;
    ready_model = 1'b1;
  endtask

  task automatic wait_pops(input int target);
    int n;
    n = 0;
    while (pops < target && n < POP_TIMEOUT)
    begin
      next_cycle();
      n++;
    end
    if (pops < target)
    begin
      timeouts++;
      $display("timeout while waiting for an instruction pop");
    end
  endtask

  task automatic wait_load_done();
    int n;
    n = 0;
    while (!o_idle && n < LOAD_TIMEOUT)
    begin
      next_cycle();
      n++;
    end
    if (!o_idle)
    begin
      timeouts++;
      $display("timeout while waiting for the load to return to idle");
    end
  endtask

  // push one word, optionally with the activation fifo held full
  task automatic forward_word(input instr_t word, input logic hold, input int target);
    i_fwd_full = hold;
    instr_q.push_back(word);
    present_head();
    if (hold)
    begin
      repeat (HOLD_CYCLES) next_cycle();
      check_count("o_instr_rd_en while full", pops, target - 1);
      i_fwd_full = 1'b0;
    end
    wait_pops(target);
  endtask

  task automatic check_row(input row_t row);
    int exp_ars;
    exp_ars = (row.word[31:29] == OP_LOAD_WEIGHT) ? 2 : 0;
    check_count("o_fwd_wr_en words", fwd_q.size(), row.exp_words);
    if (fwd_q.size() > 0)
    begin
      check_instr("forwarded word 0", fwd_q[0], row.word);
    end
    if (fwd_q.size() > 1)
    begin
      check_instr("forwarded word 1", fwd_q[1], row.word2);
    end
    check_count("o_ar requests", ar_addr_q.size(), exp_ars);
    if (exp_ars == 2 && ar_addr_q.size() == 2)
    begin
      check_addr("o_ar.araddr first", ar_addr_q[0], row.exp_addr0);
      check_addr("o_ar.araddr second", ar_addr_q[1], row.exp_addr1);
      check_len("o_ar.arlen first", ar_len_q[0], row.exp_len0);
      check_len("o_ar.arlen second", ar_len_q[1], row.exp_len1);
    end
    check_count("weight beats", beats, row.exp_beats);
    check_count("o_prepare_weight pulses", preps, row.exp_prep);
    check_count("o_bias_wr_en pulses", biases, row.exp_bias);
    check_bit("o_idle", o_idle, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    row_t row;
    int   r;
    int   pops0;
    int   n;
    // word, word2, full, set, bad, words, addr0, addr1, len0, len1, beats, prep, bias
    rows[0] = '{32'h6000_00a5, 32'h0, 1'b1, 1'b0, 1'b0, 1,
                32'h0, 32'h0, 8'd0, 8'd0, 0, 0, 0};
    rows[1] = '{32'h4000_1234, 32'h7123_4567, 1'b1, 1'b0, 1'b0, 2,
                32'h0, 32'h0, 8'd0, 8'd0, 0, 0, 0};
    rows[2] = '{32'h2012_3456, 32'h0, 1'b0, 1'b0, 1'b0, 0,
                32'h8048_d158, 32'h8048_d558, 8'd255, 8'd31, 288, 9, 0};
    // bias mode, and ready flag still clear from the row before
    rows[3] = '{32'h3000_ff10, 32'h0, 1'b0, 1'b0, 1'b0, 0,
                32'h8003_fc40, 32'h8004_0040, 8'd255, 8'd127, 384, 12, 1};
    // line carry wraps, bad beats mixed in
    rows[4] = '{32'h23ff_ff05, 32'h0, 1'b0, 1'b1, 1'b1, 0,
                32'h8fff_fc14, 32'h8000_0014, 8'd255, 8'd31, 288, 9, 0};
    rows[5] = '{32'h1abc_def0, 32'h0, 1'b0, 1'b0, 1'b0, 1,
                32'h0, 32'h0, 8'd0, 8'd0, 0, 0, 0};

    repeat (16) @(negedge clk);
    // outputs while still in reset
    check_bit("o_ar.arvalid", o_ar.arvalid, 1'b0);
    check_bit("o_rready", o_rready, 1'b0);
    check_bit("o_instr_rd_en", o_instr_rd_en, 1'b0);
    check_bit("o_fwd_wr_en", o_fwd_wr_en, 1'b0);
    check_bit("o_prepare_weight", o_prepare_weight, 1'b0);
    check_bit("o_bias_wr_en", o_bias_wr_en, 1'b0);
    check_bit("o_param_wr_en", o_param_wr_en, 1'b0);
    check_bit("o_idle", o_idle, 1'b1);
    rst_n = 1'b1;
    next_cycle();

    for (r = 0; r < NUM_ROWS && timeouts == 0; r++)
    begin
      row = rows[r];
      pops0 = pops;
      fwd_q.delete();
      ar_addr_q.delete();
      ar_len_q.delete();
      beats = 0;
      preps = 0;
      biases = 0;
      inject_bad = row.bad_beats;
      bias_row = row.word[28];
      if (row.set_before)
      begin
        pulse_set_weight();
      end
      if (row.word[31:29] == OP_LOAD_WEIGHT)
      begin
        instr_q.push_back(row.word);
        present_head();
        // previous weights not taken yet, load must wait
        if (!ready_model)
        begin
          for (n = 0; n < GATE_CYCLES; n++)
          begin
            next_cycle();
            check_bit("o_idle", o_idle, 1'b1);
          end
          check_count("o_instr_rd_en while gated", pops, pops0);
          pulse_set_weight();
        end
        wait_pops(pops0 + 1);
        ready_model = 1'b0;
        wait_load_done();
        // room for the delayed bias strobe
        repeat (4) next_cycle();
      end
      else
      begin
        forward_word(row.word, row.hold_full, pops0 + 1);
        if (row.word[31:29] == OP_EXECUTE && timeouts == 0)
        begin
          // fifo runs dry before the second word
          repeat (HOLD_CYCLES) next_cycle();
          forward_word(row.word2, row.hold_full, pops0 + 2);
        end
        repeat (3) next_cycle();
      end
      if (timeouts == 0)
      begin
        check_row(row);
      end
    end

    $display("errors: %0d failed checks, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
weight_load_pkg.sv
weight_ar_gen.sv
weight_beat_counter.sv
weight_load_fsm.sv
weight_load_top.sv
tb_weight_load.sv

// File: weight_ar_gen.sv
`timescale 1ns/100ps
`default_nettype none

module weight_ar_gen
  import weight_load_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  ar_cmd_t  i_cmd,
  input  logic     i_arready,
  output ar_chan_t o_ar,
  output logic     o_ar_done
);

  logic       arvalid_q;
  // word address of the current burst
  line_addr_t line_q;
  len_hi_t    len_hi_q;

  assign o_ar_done = arvalid_q & i_arready;

  // arvalid up after an issue, down after the handshake
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      arvalid_q <= 1'b0;
    end
    else if (i_cmd.issue_first || i_cmd.issue_second)
    begin
      arvalid_q <= 1'b1;
    end
    else if (o_ar_done)
    begin
      arvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_cmd.issue_first)
    begin
      line_q   <= i_cmd.line;
      len_hi_q <= FIRST_LEN_HI;
    end
    else if (i_cmd.issue_second)
    begin
      // step to the next 256-beat line
      line_q   <= {line_q[25:8] + 18'd1, line_q[7:0]};
      len_hi_q <= i_cmd.bias_mode ? BIAS_LEN_HI : PLAIN_LEN_HI;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // channel fields
  //////////////////////////////////////////////////////////////////////////

  assign o_ar.arvalid = arvalid_q;
  // base nibble, word address, byte offset
  assign o_ar.araddr  = {WEIGHT_RD_BASE, line_q, 2'b00};
  assign o_ar.arid    = WEIGHT_MEM_ID;
  // whole chunks only
  assign o_ar.arlen   = {len_hi_q, 5'b11111};
  assign o_ar.arsize  = AR_SIZE_4B;
  assign o_ar.arburst = AR_BURST_INCR;

endmodule

`default_nettype wire

// File: weight_beat_counter.sv
`timescale 1ns/100ps
`default_nettype none

module weight_beat_counter
  import weight_load_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      i_ar_done,
  input  r_chan_t   i_r,
  output logic      o_rready,
  output logic      o_weight_wr_en,
  output beat_sel_t o_weight_sel,
  output logic      o_prepare_weight,
  output logic      o_burst_end
);

  localparam beat_sel_t LAST_SEL = beat_sel_t'(CHUNK_BEATS - 1);

  logic      rready_q;
  beat_sel_t sel_q;
  logic      prepare_q;

  // good beat: right id and no slverr/decerr
  logic accept;
  logic chunk_last;

  assign accept = i_r.rvalid & rready_q & (i_r.rid == WEIGHT_MEM_ID) & ~i_r.rresp[1];
  assign chunk_last = (sel_q == LAST_SEL);

  // a burst only ends on a chunk boundary
  assign o_burst_end = accept & i_r.rlast & chunk_last;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      rready_q  <= 1'b0;
      sel_q     <= '0;
      prepare_q <= 1'b0;
    end
    else
    begin
      if (i_ar_done)
      begin
        rready_q <= 1'b1;
      end
      else if (o_burst_end)
      begin
        rready_q <= 1'b0;
      end
      // index restarts with each burst, wraps at 32
      if (i_ar_done)
      begin
        sel_q <= '0;
      end
      else if (accept)
      begin
        sel_q <= sel_q + 5'd1;
      end
      // chunk complete, delayed by one
      prepare_q <= accept & chunk_last;
    end
  end

  assign o_rready         = rready_q;
  assign o_weight_wr_en   = accept;
  assign o_weight_sel     = sel_q;
  assign o_prepare_weight = prepare_q;

endmodule

`default_nettype wire

// File: weight_load_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module weight_load_fsm
  import weight_load_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    i_instr_empty,
  input  instr_t  i_instr,
  input  logic    i_fwd_full,
  input  logic    i_set_weight,
  input  logic    i_ar_done,
  input  logic    i_burst_end,
  output logic    o_instr_rd_en,
  output logic    o_fwd_wr_en,
  output ar_cmd_t o_ar_cmd,
  output logic    o_bias_wr_en,
  output logic    o_param_wr_en,
  output logic    o_idle
);

  lw_state_t state_q;
  lw_state_t state_d;

  // head word opcode
  opcode_t opcode;

  logic ready_q;
  // second burst in flight
  logic second_q;
  logic bias_q;

  logic issue_first;
  logic issue_second;
  // last beat of the second burst
  logic load_end;

  // two stage delay for bias and param strobes
  logic strobe_q1;
  logic strobe_q2;

  assign opcode = i_instr[31:29];

  //////////////////////////////////////////////////////////////////////////
  // next state and fifo handshakes
  //////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d       = state_q;
    o_instr_rd_en = 1'b0;
    o_fwd_wr_en   = 1'b0;
    issue_first   = 1'b0;
    issue_second  = 1'b0;
    load_end      = 1'b0;
    case (state_q)
      S_IDLE:
      begin
        if (!i_instr_empty)
        begin
          if (opcode == OP_LOAD_WEIGHT)
          begin
            // held back until the array took the last set
            if (ready_q)
            begin
              o_instr_rd_en = 1'b1;
              issue_first   = 1'b1;
              state_d       = S_ADDR;
            end
          end
          else if (!i_fwd_full)
          begin
            // everything else goes to the activation side
            o_instr_rd_en = 1'b1;
            o_fwd_wr_en   = 1'b1;
            if (opcode == OP_EXECUTE)
            begin
              state_d = S_FETCH_EX;
            end
          end
        end
      end
      S_ADDR:
      begin
        if (i_ar_done)
        begin
          state_d = S_BURST;
        end
      end
      S_BURST:
      begin
        if (i_burst_end)
        begin
          if (second_q)
          begin
            load_end = 1'b1;
            state_d  = S_IDLE;
          end
          else
          begin
            issue_second = 1'b1;
            state_d      = S_ADDR;
          end
        end
      end
      S_FETCH_EX:
      begin
        // lower half of the execute pair
        if (!i_instr_empty && !i_fwd_full)
        begin
          o_instr_rd_en = 1'b1;
          o_fwd_wr_en   = 1'b1;
          state_d       = S_IDLE;
        end
      end
      default:
      begin
        state_d = S_IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // control registers
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q   <= S_IDLE;
      ready_q   <= 1'b1;
      second_q  <= 1'b0;
      strobe_q1 <= 1'b0;
      strobe_q2 <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // set-weight wins over the clear
      if (i_set_weight)
      begin
        ready_q <= 1'b1;
      end
      else if (state_q == S_ADDR)
      begin
        ready_q <= 1'b0;
      end
      if (issue_first)
      begin
        second_q <= 1'b0;
      end
      else if (issue_second)
      begin
        second_q <= 1'b1;
      end
      strobe_q1 <= load_end & bias_q;
      strobe_q2 <= strobe_q1;
    end
  end

  // bias mode from bit 28 of the load word
  always_ff @(posedge clk)
  begin
    if (issue_first)
    begin
      bias_q <= i_instr[28];
    end
  end

  assign o_ar_cmd = '{
    issue_first:  issue_first,
    issue_second: issue_second,
    bias_mode:    bias_q,
    line:         i_instr[25:0]
  };

  assign o_bias_wr_en  = strobe_q2;
  assign o_param_wr_en = strobe_q2;
  assign o_idle        = (state_q == S_IDLE);

endmodule

`default_nettype wire

// File: weight_load_pkg.sv
`default_nettype none

package weight_load_pkg;

  //////////////////////////////////////////////////////////////////////////
  // constants
  //////////////////////////////////////////////////////////////////////////

  // weight memory window and read id
  localparam logic [3:0] WEIGHT_RD_BASE = 4'h8;
  localparam logic [3:0] WEIGHT_MEM_ID  = 4'd2;

  // beats per prepare chunk
  localparam int CHUNK_BEATS = 32;

  // upper arlen bits, low five bits are always ones
  localparam logic [2:0] FIRST_LEN_HI = 3'd7;
  localparam logic [2:0] BIAS_LEN_HI  = 3'd3;
  localparam logic [2:0] PLAIN_LEN_HI = 3'd0;

  // fixed burst attributes, 32-bit beats and incrementing
  localparam logic [2:0] AR_SIZE_4B    = 3'b010;
  localparam logic [1:0] AR_BURST_INCR = 2'b01;

  // instruction opcodes in bits 31..29
  localparam logic [2:0] OP_LOAD_WEIGHT = 3'd1;
  localparam logic [2:0] OP_EXECUTE     = 3'd2;

  //////////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] instr_t;
  typedef logic [2:0]  opcode_t;
  typedef logic [25:0] line_addr_t;
  typedef logic [31:0] axi_addr_t;
  typedef logic [3:0]  axi_id_t;
  typedef logic [7:0]  axi_len_t;
  typedef logic [2:0]  len_hi_t;
  typedef logic [4:0]  beat_sel_t;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,
    S_BURST,
    S_FETCH_EX
  } lw_state_t;

  // read address channel, master to slave
  typedef struct packed {
    logic      arvalid;
    axi_addr_t araddr;
    axi_id_t   arid;
    axi_len_t  arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
  } ar_chan_t;

  // read data channel control, slave to master
  typedef struct packed {
    logic       rvalid;
    logic       rlast;
    axi_id_t    rid;
    logic [1:0] rresp;
  } r_chan_t;

  // fsm request to the address generator
  typedef struct packed {
    logic       issue_first;
    logic       issue_second;
    logic       bias_mode;
    line_addr_t line;
  } ar_cmd_t;

endpackage

`default_nettype wire

// File: weight_load_top.sv
`timescale 1ns/100ps
`default_nettype none

module weight_load_top
  import weight_load_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  // instruction fifo, fwft
  input  logic      i_instr_empty,
  input  instr_t    i_instr,
  output logic      o_instr_rd_en,
  // activation-load fifo
  input  logic      i_fwd_full,
  output logic      o_fwd_wr_en,
  // array has taken the previous weights
  input  logic      i_set_weight,
  // axi4 read master
  output ar_chan_t  o_ar,
  input  logic      i_arready,
  input  r_chan_t   i_r,
  output logic      o_rready,
  // weight register file side
  output logic      o_weight_wr_en,
  output beat_sel_t o_weight_sel,
  output logic      o_prepare_weight,
  output logic      o_bias_wr_en,
  output logic      o_param_wr_en,
  output logic      o_idle
);

  // fsm to address generator
  ar_cmd_t ar_cmd;
  // address handshake pulse
  logic    ar_done;
  // last beat of the current burst
  logic    burst_end;

  weight_load_fsm u_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_instr_empty (i_instr_empty),
    .i_instr       (i_instr),
    .i_fwd_full    (i_fwd_full),
    .i_set_weight  (i_set_weight),
    .i_ar_done     (ar_done),
    .i_burst_end   (burst_end),
    .o_instr_rd_en (o_instr_rd_en),
    .o_fwd_wr_en   (o_fwd_wr_en),
    .o_ar_cmd      (ar_cmd),
    .o_bias_wr_en  (o_bias_wr_en),
    .o_param_wr_en (o_param_wr_en),
    .o_idle        (o_idle)
  );

  weight_ar_gen u_ar_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_cmd     (ar_cmd),
    .i_arready (i_arready),
    .o_ar      (o_ar),
    .o_ar_done (ar_done)
  );

  weight_beat_counter u_beat_counter (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_ar_done        (ar_done),
    .i_r              (i_r),
    .o_rready         (o_rready),
    .o_weight_wr_en   (o_weight_wr_en),
    .o_weight_sel     (o_weight_sel),
    .o_prepare_weight (o_prepare_weight),
    .o_burst_end      (burst_end)
  );

endmodule

`default_nettype wire
